/* files.f */
hdl/sprite_pkg.sv
hdl/sprite_attr_ram.sv
hdl/sprite_renderer.sv
hdl/line_buffer.sv
hdl/line_output.sv
hdl/sprite_engine.sv
verif/sprite_engine_assertions.sv
verif/sprite_engine_tb.sv

/* Makefile */
# Verilator build and run of the sprite engine testbench

VERILATOR ?= verilator
TOP       ?= sprite_engine_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

SRCS    := $(filter-out +incdir%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
		! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/sprite_engine_tb.sv */
// Sprite engine testbench
// Table driven rows of sprite attributes and memory words, a memory model
// with random latency, and a full scanline readout compared per pixel

module sprite_engine_tb
	import sprite_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SPRITE_BITS = 4;
	localparam int LINE_PIXELS = 800;
	localparam int NUM_ROWS    = 5;
	// The power-up flush sweep counts as one extra row
	localparam int WATCHDOG_CYCLES = (NUM_ROWS + 1) * 1500;
	localparam int SLOT_IDX [2] = '{2, 9};

	// Per sprite: X, Y, H, A words; sprite 0 first
	localparam logic [15:0] SPR [NUM_ROWS][8] = '{
		'{16'h2C64, 16'h1C14, 16'h001E, 16'h0200, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'hDD2C, 16'h2028, 16'h8032, 16'h0380, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h2864, 16'h1C14, 16'h001E, 16'h0200, 16'h2C64, 16'h1C1A, 16'h001E, 16'h0200},
		'{16'h14C8, 16'h1C0A, 16'h0014, 16'h04B0, 16'hCCCC, 16'h1C0A, 16'h0014, 16'h04C4},
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};
	localparam logic [COORD_W-1:0] DISP_Y [NUM_ROWS] = '{10'd20, 10'd42, 10'd25, 10'd11, 10'd20};
	// Eight memory words per row, starting at MEM_BASE
	localparam logic [15:0] MEM_BASE [NUM_ROWS] = '{16'h0200, 16'h0400, 16'h0200, 16'h0500, 16'h0200};
	localparam logic [15:0] MEM [NUM_ROWS][8] = '{
		'{16'h4301, 16'h0F0A, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h001F, 16'h8421, 16'h7FFF, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h4301, 16'h0F0A, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'h1111, 16'h2222, 16'h0000, 16'h0000, 16'h0F0F, 16'h3333, 16'h0000, 16'h0000},
		'{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};

	logic                   CLK = 1'b0;
	logic                   RSTb;
	logic [SPRITE_BITS+1:0] ADDRESS;
	logic [15:0]            DATA_IN;
	logic                   WR;
	logic                   H_tick;
	logic [COORD_W-1:0]     display_x;
	logic [COORD_W-1:0]     display_y;
	logic                   re;
	logic [COLOR_W-1:0]     color_index;
	logic [15:0]            memory_address;
	logic [15:0]            memory_data;
	logic                   rvalid;
	logic                   rready;

	int                 seed = 55682;
	int                 errors = 0;
	int                 checks = 0;
	int                 cur_row = 0;
	bit                 addr_check_on = 1'b0;
	logic [COLOR_W-1:0] exp_line [LINE_PIXELS];
	logic [15:0]        exp_addr [$];

	sprite_engine #(.SPRITE_BITS(SPRITE_BITS), .LINE_PIXELS(LINE_PIXELS)) sprite_engine_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.H_tick(H_tick),
		.display_x(display_x),
		.display_y(display_y),
		.re(re),
		.color_index(color_index),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready)
	);

	always #4 CLK = ~CLK;

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_color(input logic [COLOR_W-1:0] exp, input logic [COLOR_W-1:0] act,
		input int x);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR color_index x=%0d expected %h got %h", x, exp, act);
		end
	endtask

	task automatic check_addr(input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR memory_address expected %h got %h", exp, act);
		end
	endtask

	// Words outside the row's table follow a pattern of the full address
	function automatic logic [15:0] mem_word(input int r, input logic [15:0] addr);
		logic [15:0] off;
		off = addr - MEM_BASE[r];
		if (off < 16'd8)
			return MEM[r][off[2:0]];
		return {addr[7:0], addr[15:8]} ^ 16'hA5C3;
	endfunction

	// Reference line and fetch order from the sprite rules
	task automatic build_expected(input int r);
		logic [15:0]        xw;
		logic [15:0]        yw;
		logic [15:0]        hw;
		logic [15:0]        addr;
		logic [15:0]        w;
		logic [COORD_W-1:0] v;
		logic [COORD_W-1:0] px;
		logic [4:0]         val;
		int                 n;
		int                 ppw;
		int                 lane;
		exp_addr.delete();
		for (int i = 0; i < LINE_PIXELS; i++)
			exp_line[i] = '0;
		for (int s = 0; s < 2; s++) begin
			xw = SPR[r][4*s];
			yw = SPR[r][4*s+1];
			hw = SPR[r][4*s+2];
			if (!xw[10] || DISP_Y[r] < yw[9:0] || DISP_Y[r] > hw[9:0])
				continue;
			v   = DISP_Y[r] - yw[9:0];
			ppw = hw[15] ? 3 : 4;
			n   = yw[15:10] + 1;
			for (int u = 0; u < n; u++) begin
				lane = u % ppw;
				addr = SPR[r][4*s+3] + v * (xw[15] ? 16'd64 : 16'd80) + 16'(u / ppw);
				if (lane == 0)
					exp_addr.push_back(addr);
				w   = mem_word(r, addr);
				val = hw[15] ? 5'(w >> (5 * lane)) : {1'b0, 4'(w >> (4 * lane))};
				px  = xw[9:0] + COORD_W'(u);
				if (val != 5'd0 && px < LINE_PIXELS)
					exp_line[px] = hw[15] ? {xw[14:12], val} : {xw[14:11], val[3:0]};
			end
		end
	endtask

	task automatic host_write(input logic [1:0] sel, input int idx, input logic [15:0] data);
		ADDRESS = {sel, idx[SPRITE_BITS-1:0]};
		DATA_IN = data;
		WR      = 1'b1;
		next_cycle();
		WR      = 1'b0;
	endtask

	task automatic pulse_h_tick();
		H_tick = 1'b1;
		next_cycle();
		H_tick = 1'b0;
	endtask

	task automatic sweep_line(input bit check);
		int probe;
		probe = 0;
		for (int x = LINE_PIXELS - 1; x >= 0; x--)
			if (exp_line[x] != '0)
				probe = x;
		// Leftmost opaque pixel read with re low gives color 0
		display_x = COORD_W'(probe);
		re        = 1'b0;
		next_cycle();
		if (check)
			check_color(8'h00, color_index, probe);
		// That read cleared the pixel behind it
		exp_line[(probe == 0) ? LINE_PIXELS - 1 : probe - 1] = '0;
		for (int x = 0; x < LINE_PIXELS; x++) begin
			display_x = COORD_W'(x);
			re        = 1'b1;
			next_cycle();
			if (check)
				check_color(exp_line[x], color_index, x);
		end
		display_x = '0;
		re        = 1'b0;
	endtask

	// Memory with 1 to 4 cycles of latency per request
	initial begin : memory_model
		int delay;
		bit pending;
		rready      = 1'b0;
		memory_data = '0;
		pending     = 1'b0;
		delay       = 0;
		forever begin
			next_cycle();
			rready = 1'b0;
			if (!rvalid) begin
				pending = 1'b0;
			end else if (!pending) begin
				pending = 1'b1;
				delay   = 1 + ($random(seed) & 3);
				if (addr_check_on && exp_addr.size() == 0) begin
					errors++;
					$display("Unexpected memory request at address %h", memory_address);
				end else if (addr_check_on) begin
					check_addr(exp_addr.pop_front(), memory_address);
				end
			end
			if (pending) begin
				delay--;
				if (delay == 0) begin
					rready      = 1'b1;
					memory_data = mem_word(cur_row, memory_address);
					pending     = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int c0;
		int e0;
		RSTb      = 1'b0;
		ADDRESS   = '0;
		DATA_IN   = '0;
		WR        = 1'b0;
		H_tick    = 1'b0;
		display_x = '0;
		display_y = '0;
		re        = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		RSTb = 1'b1;
		// Flush the power-up contents of the front buffer
		sweep_line(1'b0);
		for (int r = 0; r < NUM_ROWS; r++) begin
			c0      = checks;
			e0      = errors;
			cur_row = r;
			for (int i = 0; i < 2 ** SPRITE_BITS; i++)
				host_write(TABLE_SEL_X, i, 16'h0000);
			for (int s = 0; s < 2; s++) begin
				host_write(TABLE_SEL_Y, SLOT_IDX[s], SPR[r][4*s+1]);
				host_write(TABLE_SEL_H, SLOT_IDX[s], SPR[r][4*s+2]);
				host_write(TABLE_SEL_A, SLOT_IDX[s], SPR[r][4*s+3]);
				host_write(TABLE_SEL_X, SLOT_IDX[s], SPR[r][4*s]);
			end
			build_expected(r);
			display_y = DISP_Y[r];
			pulse_h_tick();
			addr_check_on = 1'b1;
			repeat (600) next_cycle();
			addr_check_on = 1'b0;
			if (exp_addr.size() != 0) begin
				errors++;
				$display("Row %0d is missing %0d memory fetches", r, exp_addr.size());
			end
			if (rvalid) begin
				errors++;
				$display("Row %0d still has a memory request open after rendering", r);
			end
			pulse_h_tick();
			sweep_line(1'b1);
			$display("row %0d: %s, %0d checks, %0d errors", r,
				(errors == e0) ? "ok" : "mismatch", checks - c0, errors - e0);
		end
		$display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* verif/sprite_engine_assertions.sv */
// Sprite engine protocol assertions
// Memory request stability, rvalid reset state and back buffer only writes

module sprite_engine_assertions
	import sprite_pkg::*;
(
	input logic           CLK,
	input logic           RSTb,
	input logic           rvalid,
	input logic           rready,
	input logic [15:0]    memory_address,
	input logic [1:0]     is_front,
	input line_wr_t [1:0] line_wr
);
	timeunit 1ns;
	timeprecision 100ps;

	// Address held until the memory answers
	property addr_stable_p;
		@(posedge CLK) disable iff (!RSTb)
			rvalid && !rready |=> $stable(memory_address);
	endproperty

	addr_stable_a: assert property (addr_stable_p)
		else $error("memory_address changed while rvalid waited for rready");

	rvalid_reset_a: assert property (@(posedge CLK) !RSTb |=> !rvalid)
		else $error("rvalid high after a reset cycle");

	// Renderer writes never reach the buffer on display
	back_only_a: assert property (@(posedge CLK) disable iff (!RSTb)
		!(line_wr[0].en && is_front[0]) && !(line_wr[1].en && is_front[1]))
		else $error("renderer wrote the line buffer that is being displayed");

endmodule

bind sprite_engine sprite_engine_assertions sprite_engine_assertions_i (
	.CLK(CLK),
	.RSTb(RSTb),
	.rvalid(rvalid),
	.rready(rready),
	.memory_address(memory_address),
	.is_front(is_front),
	.line_wr(line_wr)
);

/* hdl/sprite_engine.sv */
// Sprite engine top level
// Attribute tables, scanline renderer, double line buffer and output stage

module sprite_engine
	import sprite_pkg::*;
#(
	parameter int SPRITE_BITS = 8,
	parameter int LINE_PIXELS = 800
) (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic [SPRITE_BITS+1:0] ADDRESS,
	input  logic [15:0]            DATA_IN,
	input  logic                   WR,
	input  logic                   H_tick,
	input  logic [COORD_W-1:0]     display_x,
	input  logic [COORD_W-1:0]     display_y,
	input  logic                   re,
	output logic [COLOR_W-1:0]     color_index,
	output logic [15:0]            memory_address,
	input  logic [15:0]            memory_data,
	output logic                   rvalid,
	input  logic                   rready
);

	sprite_attr_t                attr;
	logic [SPRITE_BITS-1:0]      sprite_index;
	line_wr_t [1:0]              line_wr;
	logic                        back_sel;
	logic [1:0]                  is_front;
	logic [1:0][COORD_W-1:0]     rd_addr;
	logic [1:0][COLOR_W-1:0]     rd_data;

	sprite_attr_ram #(.SPRITE_BITS(SPRITE_BITS)) sprite_attr_ram_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.sprite_index(sprite_index),
		.attr(attr)
	);

	sprite_renderer #(.SPRITE_BITS(SPRITE_BITS)) sprite_renderer_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.display_y(display_y),
		.attr(attr),
		.sprite_index(sprite_index),
		.memory_address(memory_address),
		.rvalid(rvalid),
		.memory_data(memory_data),
		.rready(rready),
		.back_sel(back_sel),
		.line_wr(line_wr)
	);

	// Double scanline buffer
	for (genvar i = 0; i < 2; i++) begin : g_buf
		line_buffer #(.LINE_PIXELS(LINE_PIXELS)) line_buffer_i (
			.CLK(CLK),
			.is_front(is_front[i]),
			.rd_addr(rd_addr[i]),
			.rd_data(rd_data[i]),
			.wr(line_wr[i])
		);
	end

	line_output line_output_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.re(re),
		.display_x(display_x),
		.back_sel(back_sel),
		.is_front(is_front),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.color_index(color_index)
	);

endmodule

/* hdl/line_output.sv */
// Scanline output stage
// Swaps front and back buffers on H_tick and muxes the front buffer to color_index

module line_output
	import sprite_pkg::*;
(
	input  logic                        CLK,
	input  logic                        RSTb,
	input  logic                        H_tick,
	input  logic                        re,
	input  logic [COORD_W-1:0]          display_x,
	output logic                        back_sel,
	output logic [1:0]                  is_front,
	output logic [1:0][COORD_W-1:0]     rd_addr,
	input  logic [1:0][COLOR_W-1:0]     rd_data,
	output logic [COLOR_W-1:0]          color_index
);

	logic re_q;
	logic front_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			back_sel <= 1'b0;
			re_q     <= 1'b0;
			front_q  <= 1'b0;
		end else begin
			if (H_tick)
				back_sel <= ~back_sel;
			// Track the buffer that was read along with re
			re_q    <= re;
			front_q <= ~back_sel;
		end
	end

	assign is_front = {~back_sel, back_sel};

	// Only the front buffer follows display_x
	always_comb begin
		rd_addr            = '0;
		rd_addr[~back_sel] = display_x;
	end

	assign color_index = re_q ? rd_data[front_q] : '0;

endmodule

/* hdl/line_buffer.sv */
// Scanline buffer
// Takes renderer writes as the back buffer, clears one pixel behind the
// display read as the front buffer

module line_buffer
	import sprite_pkg::*;
#(
	parameter int LINE_PIXELS = 800
) (
	input  logic               CLK,
	input  logic               is_front,
	input  logic [COORD_W-1:0] rd_addr,
	output logic [COLOR_W-1:0] rd_data,
	input  line_wr_t           wr
);

	logic [COLOR_W-1:0] mem [LINE_PIXELS];

	logic [COORD_W-1:0] clr_addr;
	logic [COORD_W-1:0] wr_addr;
	logic               wr_en;

	// Wraps from pixel 0 back to the end of the line
	assign clr_addr = (rd_addr == '0) ? COORD_W'(LINE_PIXELS - 1) : rd_addr - 1'b1;
	assign wr_addr  = is_front ? clr_addr : wr.addr;
	// Sprites running off the right edge are dropped here
	assign wr_en    = (is_front || wr.en) && wr_addr < LINE_PIXELS;

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= is_front ? '0 : wr.color;
		rd_data <= mem[rd_addr];
	end

endmodule

/* hdl/sprite_renderer.sv */
// Sprite scanline renderer
// After each H_tick walks all sprite entries, fetches pixel words for the
// sprites on display_y and writes their opaque pixels into the back buffer

module sprite_renderer
	import sprite_pkg::*;
#(
	parameter int SPRITE_BITS = 8
) (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic                   H_tick,
	input  logic [COORD_W-1:0]     display_y,
	input  sprite_attr_t           attr,
	output logic [SPRITE_BITS-1:0] sprite_index,
	output logic [15:0]            memory_address,
	output logic                   rvalid,
	input  logic [15:0]            memory_data,
	input  logic                   rready,
	input  logic                   back_sel,
	output line_wr_t [1:0]         line_wr
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_BEGIN,
		S_TEST,
		S_ADDR,
		S_WAIT,
		S_PIX0,
		S_PIX1,
		S_PIX2,
		S_PIX3,
		S_NEXT
	} state_t;

	state_t             state;
	logic [COORD_W-1:0] row_v;
	logic [COORD_W-1:0] x_cur;
	logic [5:0]         pix_cnt;
	logic [5:0]         fetch_cnt;
	pix_word_u          word;

	logic               visible;
	logic [15:0]        row_off;
	logic [15:0]        fetch_addr;
	logic               in_pix;
	logic               last_pix;
	logic               last_lane;
	logic [1:0]         lane;
	logic [4:0]         pix_val;
	logic [COLOR_W-1:0] pix_color;

	assign visible = attr.x.enable && display_y >= attr.y.y_start &&
		display_y <= attr.h.y_end;

	// Row offset is v * 64 or v * 80
	assign row_off = attr.x.stride ? {row_v, 6'd0} :
		{row_v, 6'd0} + {2'd0, row_v, 4'd0};
	assign fetch_addr = attr.base + row_off + {10'd0, fetch_cnt};

	assign in_pix   = state inside {S_PIX0, S_PIX1, S_PIX2, S_PIX3};
	assign last_pix = pix_cnt == attr.y.width;

	// Pixel lane within the fetched word and its color
	always_comb begin
		case (state)
			S_PIX1: lane = 2'd1;
			S_PIX2: lane = 2'd2;
			S_PIX3: lane = 2'd3;
			default: lane = 2'd0;
		endcase
		if (attr.h.depth) begin
			pix_val   = word.p5.pix[lane];
			pix_color = {attr.x.palette[3:1], pix_val};
			last_lane = lane == 2'd2;
		end else begin
			pix_val   = {1'b0, word.pix4[lane]};
			pix_color = {attr.x.palette, pix_val[3:0]};
			last_lane = lane == 2'd3;
		end
		line_wr = '0;
		// Zero pixels are transparent
		line_wr[back_sel].en    = in_pix && pix_val != 5'd0;
		line_wr[back_sel].addr  = x_cur;
		line_wr[back_sel].color = pix_color;
	end

	// H_tick abandons whatever is in flight
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state        <= S_IDLE;
			sprite_index <= '0;
			rvalid       <= 1'b0;
		end else if (H_tick) begin
			state        <= S_BEGIN;
			sprite_index <= '0;
			rvalid       <= 1'b0;
		end else begin
			case (state)
				S_IDLE: ;
				// Wait for the attribute read
				S_BEGIN: state <= S_TEST;
				S_TEST: state <= visible ? S_ADDR : S_NEXT;
				S_ADDR: begin
					rvalid <= 1'b1;
					state  <= S_WAIT;
				end
				S_WAIT: begin
					if (rready) begin
						rvalid <= 1'b0;
						state  <= S_PIX0;
					end
				end
				S_NEXT: begin
					if (sprite_index == '1) begin
						state <= S_IDLE;
					end else begin
						sprite_index <= sprite_index + 1'b1;
						state        <= S_BEGIN;
					end
				end
				default: begin
					if (last_pix)
						state <= S_NEXT;
					else if (last_lane)
						state <= S_ADDR;
					else
						state <= state_t'(state + 4'd1);
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (state)
			S_TEST: begin
				row_v     <= display_y - attr.y.y_start;
				x_cur     <= attr.x.x_pos;
				pix_cnt   <= 6'd0;
				fetch_cnt <= 6'd0;
			end
			// Address stays put for the whole request
			S_ADDR: memory_address <= fetch_addr;
			S_WAIT: begin
				if (rready) begin
					word      <= memory_data;
					fetch_cnt <= fetch_cnt + 1'b1;
				end
			end
			default: ;
		endcase
		if (in_pix) begin
			x_cur   <= x_cur + 1'b1;
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

endmodule

/* hdl/sprite_attr_ram.sv */
// Sprite attribute tables
// Four tables (X, Y, H, A) written from the host port, read as one
// registered sprite_attr_t for the renderer

module sprite_attr_ram
	import sprite_pkg::*;
#(
	parameter int SPRITE_BITS = 8
) (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic [SPRITE_BITS+1:0] ADDRESS,
	input  logic [15:0]            DATA_IN,
	input  logic                   WR,
	input  logic [SPRITE_BITS-1:0] sprite_index,
	output sprite_attr_t           attr
);

	localparam int ENTRIES = 2 ** SPRITE_BITS;

	logic [15:0] x_tbl [ENTRIES];
	logic [15:0] y_tbl [ENTRIES];
	logic [15:0] h_tbl [ENTRIES];
	logic [15:0] a_tbl [ENTRIES];

	logic [1:0]             tbl_sel;
	logic [SPRITE_BITS-1:0] wr_index;

	assign tbl_sel  = ADDRESS[SPRITE_BITS+1 -: 2];
	assign wr_index = ADDRESS[SPRITE_BITS-1:0];

	// Host write lands on the strobe edge
	always_ff @(posedge CLK) begin
		if (WR) begin
			case (tbl_sel)
				TABLE_SEL_X: x_tbl[wr_index] <= DATA_IN;
				TABLE_SEL_Y: y_tbl[wr_index] <= DATA_IN;
				TABLE_SEL_H: h_tbl[wr_index] <= DATA_IN;
				TABLE_SEL_A: a_tbl[wr_index] <= DATA_IN;
				default: ;
			endcase
		end
	end

	// All four words of one sprite, one cycle after sprite_index
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			attr <= '0;
		end else begin
			attr <= {a_tbl[sprite_index], h_tbl[sprite_index],
				y_tbl[sprite_index], x_tbl[sprite_index]};
		end
	end

endmodule

/* hdl/sprite_pkg.sv */
// Sprite engine shared definitions
// Sizes, decoded attribute words, the line buffer write and the pixel word views

package sprite_pkg;

	localparam int COORD_W = 10;
	localparam int COLOR_W = 8;

	// Table select codes in the top two bits of ADDRESS
	localparam logic [1:0] TABLE_SEL_X = 2'd0;
	localparam logic [1:0] TABLE_SEL_Y = 2'd1;
	localparam logic [1:0] TABLE_SEL_H = 2'd2;
	localparam logic [1:0] TABLE_SEL_A = 2'd3;

	// Stride 0 is 80 words per row, 1 is 64 words per row
	typedef struct packed {
		logic               stride;
		logic [3:0]         palette;
		logic               enable;
		logic [COORD_W-1:0] x_pos;
	} x_word_t;

	// Sprite is width + 1 pixels wide
	typedef struct packed {
		logic [5:0]         width;
		logic [COORD_W-1:0] y_start;
	} y_word_t;

	// Depth 0 is 4 bpp, depth 1 is 5 bpp
	typedef struct packed {
		logic               depth;
		logic [4:0]         reserved;
		logic [COORD_W-1:0] y_end;
	} h_word_t;

	typedef struct packed {
		logic [15:0] base;
		h_word_t     h;
		y_word_t     y;
		x_word_t     x;
	} sprite_attr_t;

	typedef struct packed {
		logic               en;
		logic [COORD_W-1:0] addr;
		logic [COLOR_W-1:0] color;
	} line_wr_t;

	// Three 5 bit pixels, top bit of the word unused
	typedef struct packed {
		logic            unused;
		logic [2:0][4:0] pix;
	} pix5_t;

	typedef union packed {
		logic [3:0][3:0] pix4;
		pix5_t           p5;
	} pix_word_u;

endpackage
